//--- Bender.yml
package:
  name: usb_rx

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/usb_rx_pkg.sv
      - hdl/usb_line_decoder.sv
      - hdl/usb_bit_deserializer.sv
      - hdl/usb_rx_crc.sv
      - hdl/usb_rcu.sv
      - hdl/usb_rx_fifo.sv
      - hdl/usb_rx_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/usb_rx_sva.sv
      - bench/usb_rx_checker.sv
      - bench/tb_usb_rx.sv

//--- bench/tb_usb_rx.sv
`timescale 1ns/1ns
`include "usb_rx_config.svh"

module tb_usb_rx import usb_rx_pkg::*; ();
    localparam int NUM_PACKETS = 17;
    // Longest packet is 13 bytes, plus eop, idle and the FIFO drain.
    localparam int MAX_PKT_CLKS = (13 * 8 + 7) * `USB_CLKS_PER_BIT + 250;
    localparam int TIMEOUT_CLKS = NUM_PACKETS * MAX_PKT_CLKS + 2000;

    logic       clk;
    logic       n_rst;
    logic       dp;
    logic       dm;
    logic       get_rx_data;
    rx_packet_t rx_packet;
    logic [7:0] rx_data;
    logic       rx_empty;
    logic       rx_full;
    rx_flags_t  flags;

    logic [7:0] pkt [0:15];
    int         pkt_len;
    logic       level;
    integer     seed;
    int         cycle_cnt = 0;
    int         total_fails;

    usb_rx_top uut (
        .clk(clk), .n_rst(n_rst), .dp(dp), .dm(dm), .get_rx_data(get_rx_data),
        .rx_packet(rx_packet), .rx_data(rx_data), .rx_empty(rx_empty),
        .rx_full(rx_full), .flags(flags)
    );

    usb_rx_checker chk (
        .clk(clk), .rx_packet(rx_packet), .flags(flags), .rx_data(rx_data),
        .rx_empty(rx_empty), .rx_full(rx_full), .get_rx_data(get_rx_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CLKS) begin
            $display("Timeout: the run did not finish within %0d clocks", TIMEOUT_CLKS);
            $display("Simulation failed");
            $finish;
        end
    end

    // Every task starts and ends 10 ns after a rising edge.
    task drive_symbol(input logic p, input logic m);
        dp = p;
        dm = m;
        repeat (`USB_CLKS_PER_BIT) @(posedge clk);
        #10;
    endtask

    task send_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            if (!b[i]) begin
                level = ~level; // A zero is a transition.
            end
            drive_symbol(level, ~level);
        end
    endtask

    task send_eop;
        drive_symbol(1'b0, 1'b0);
        drive_symbol(1'b0, 1'b0);
        level = 1'b1;
        repeat (4) drive_symbol(1'b1, 1'b0); // Idle J between packets.
    endtask

    task make_handshake(input logic [3:0] pid);
        pkt[0] = 8'h01;
        pkt[1] = {~pid, pid};
        pkt_len = 2;
    endtask

    task make_token(input logic [3:0] pid, input logic [6:0] addr, input logic corrupt);
        logic [3:0] endp;
        logic [4:0] c5;
        endp = `USB_DEV_ENDP;
        make_handshake(pid);
        pkt[2] = {endp[0], addr};
        c5 = 5'h00;
        // The CRC field sits between endpoint bits, so search for the one that fits.
        for (int c = 0; c < 32; c++) begin
            if (chk.crc5_byte(chk.crc5_byte(5'h1f, pkt[2]), {5'(c), endp[3:1]})
                    == `USB_CRC5_RESIDUE) begin
                c5 = 5'(c);
            end
        end
        if (corrupt) begin
            c5 = c5 ^ 5'h01;
        end
        pkt[3] = {c5, endp[3:1]};
        pkt_len = 4;
    endtask

    task make_data(input logic [3:0] pid, input int n, input logic flip);
        logic [15:0] crc;
        make_handshake(pid);
        crc = 16'hffff;
        for (int i = 0; i < n; i++) begin
            pkt[2 + i] = 8'($random(seed));
            crc = chk.crc16_byte(crc, pkt[2 + i]);
        end
        pkt[2 + n] = ~crc[15:8];
        pkt[3 + n] = ~crc[7:0];
        pkt_len = n + 4;
        if (flip) begin
            pkt[2] = pkt[2] ^ (8'h01 << ($random(seed) & 7));
        end
    endtask

    task run_packet(input string name);
        int wait_cnt;
        int reads;
        chk.start_test(name);
        for (int i = 0; i < pkt_len; i++) begin
            chk.add_byte(pkt[i]);
        end
        chk.predict();
        for (int i = 0; i < pkt_len; i++) begin
            send_byte(pkt[i]);
        end
        send_eop();
        wait_cnt = 0;
        while (chk.done_cnt == 0 && chk.err_cnt == 0 && wait_cnt < 200) begin
            @(posedge clk);
            #10;
            wait_cnt++;
        end
        reads = 0;
        while (!rx_empty && reads < 2 * `USB_FIFO_DEPTH) begin
            get_rx_data = 1'b1;
            @(posedge clk);
            #10;
            get_rx_data = 1'b0;
            reads++;
        end
        chk.end_test();
    endtask

    initial begin
        logic [6:0] addr;
        logic [3:0] bad_pid;
        int         len;
        dp = 1'b1;
        dm = 1'b0;
        get_rx_data = 1'b0;
        n_rst = 1'b0;
        level = 1'b1;
        pkt_len = 0;
        seed = 1;
        repeat (4) @(posedge clk);
        #10;
        n_rst = 1'b1;
        @(posedge clk);
        #10;
        chk.check_reset();

        make_handshake(4'b0010);
        run_packet("ACK");
        make_handshake(4'b1010);
        run_packet("NAK");

        make_token(4'b0001, `USB_DEV_ADDR, 1'b0);
        run_packet("OUT token");
        make_token(4'b1001, `USB_DEV_ADDR, 1'b0);
        run_packet("IN token");
        make_token(4'b1001, `USB_DEV_ADDR, 1'b1);
        run_packet("IN token with bad CRC5");
        addr = 7'($random(seed));
        if (addr == `USB_DEV_ADDR) begin
            addr = addr ^ 7'h01;
        end
        make_token(4'b0001, addr, 1'b0);
        run_packet("OUT token for another address");

        for (int k = 0; k < 4; k++) begin
            len = 1 + (($random(seed) & 32'h7fff_ffff) % 6);
            make_data(k[0] ? 4'b1011 : 4'b0011, len, 1'b0);
            run_packet("DATA");
        end

        make_data(4'b0011, 4, 1'b1);
        run_packet("DATA with flipped bit");
        make_data(4'b1011, 3, 1'b0);
        run_packet("DATA after CRC error");

        make_handshake(4'b0010);
        pkt[0] = 8'h03;
        run_packet("bad sync");
        make_token(4'b0001, `USB_DEV_ADDR, 1'b0);
        run_packet("OUT token after bad sync");

        bad_pid = 4'($random(seed));
        while (bad_pid inside {4'b0001, 4'b1001, 4'b0011, 4'b1011, 4'b0010, 4'b1010}) begin
            bad_pid = 4'($random(seed));
        end
        make_handshake(bad_pid);
        run_packet("invalid PID");
        make_data(4'b0011, 2, 1'b0);
        run_packet("DATA after invalid PID");

        make_data(4'b0011, 9, 1'b0);
        run_packet("DATA beyond FIFO depth");

        total_fails = chk.fail_cnt + uut.u_rcu.rcu_sva.sva_fails;
        $display("Tests run: %0d, tests failed: %0d, assertion failures: %0d",
                 chk.test_cnt, chk.fail_cnt, uut.u_rcu.rcu_sva.sva_fails);
        if (total_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- bench/usb_rx_checker.sv
`timescale 1ns/1ns
`include "usb_rx_config.svh"

module usb_rx_checker import usb_rx_pkg::*; (
    input logic       clk,
    input rx_packet_t rx_packet,
    input rx_flags_t  flags,
    input logic [7:0] rx_data,
    input logic       rx_empty,
    input logic       rx_full,
    input logic       get_rx_data
);
    logic [7:0] pkt_q [$];
    logic [7:0] exp_q [$];
    rx_packet_t exp_kind;
    logic       exp_err;
    logic       exp_store;
    logic       exp_full;
    logic       full_seen;
    logic       err_prev;
    logic       active = 1'b0;
    int         done_cnt;
    int         err_cnt;
    int         store_cnt;
    int         test_errs;
    int         test_cnt = 0;
    int         fail_cnt = 0;
    string      test_name;

    // USB CRC5, polynomial x^5 + x^2 + 1, bits taken MSB first.
    function automatic logic [4:0] crc5_byte(input logic [4:0] c, input logic [7:0] b);
        logic [4:0] r;
        r = c;
        for (int i = 7; i >= 0; i--) begin
            r = (b[i] ^ r[4]) ? ({r[3:0], 1'b0} ^ 5'h05) : {r[3:0], 1'b0};
        end
        return r;
    endfunction

    // USB CRC16, polynomial 0x8005.
    function automatic logic [15:0] crc16_byte(input logic [15:0] c, input logic [7:0] b);
        logic [15:0] r;
        r = c;
        for (int i = 7; i >= 0; i--) begin
            r = (b[i] ^ r[15]) ? ({r[14:0], 1'b0} ^ 16'h8005) : {r[14:0], 1'b0};
        end
        return r;
    endfunction

    task check_value(input string name, input int expected, input int got);
        if (expected != got) begin
            $display("Error: %s expected 0x%0h got 0x%0h", name, expected, got);
            test_errs++;
        end
    endtask

    task report_test;
        test_cnt++;
        if (test_errs != 0) begin
            fail_cnt++;
        end
        $display("Test %0d %s: %s", test_cnt, test_name, (test_errs == 0) ? "PASS" : "FAIL");
    endtask

    task check_reset;
        test_name = "reset";
        test_errs = 0;
        check_value("rx_packet", PKT_IDLE, rx_packet);
        check_value("flags", 0, flags);
        check_value("rx_empty", 1, rx_empty);
        report_test();
    endtask

    task start_test(input string name);
        test_name = name;
        pkt_q.delete();
        exp_q.delete();
        done_cnt = 0;
        err_cnt = 0;
        store_cnt = 0;
        full_seen = 1'b0;
        test_errs = 0;
        err_prev = flags.r_error; // An error from the last packet is still showing.
        active = 1'b1;
    endtask

    task add_byte(input logic [7:0] b);
        pkt_q.push_back(b);
    endtask

    task predict;
        logic [15:0] c16;
        exp_kind = PKT_ERROR;
        exp_err = 1'b1;
        exp_store = 1'b0;
        exp_full = 1'b0;
        if (pkt_q.size() >= 2 && pkt_q[0] == 8'h01) begin
            case (pkt_q[1][3:0])
                4'b0001, 4'b1001: begin
                    exp_kind = pkt_q[1][3] ? PKT_IN : PKT_OUT;
                    exp_err = 1'b0;
                    // Tokens for another device are ignored, so their CRC is not judged.
                    if (pkt_q[2][6:0] == `USB_DEV_ADDR &&
                            {pkt_q[3][2:0], pkt_q[2][7]} == `USB_DEV_ENDP &&
                            crc5_byte(crc5_byte(5'h1f, pkt_q[2]), pkt_q[3])
                                != `USB_CRC5_RESIDUE) begin
                        exp_kind = PKT_ERROR;
                        exp_err = 1'b1;
                    end
                end
                4'b0011, 4'b1011: begin
                    c16 = 16'hffff;
                    for (int i = 2; i < pkt_q.size(); i++) begin
                        c16 = crc16_byte(c16, pkt_q[i]);
                        if (exp_q.size() < `USB_FIFO_DEPTH) begin
                            exp_q.push_back(pkt_q[i]);
                        end
                    end
                    exp_store = (pkt_q.size() > 2);
                    exp_full = (pkt_q.size() - 2 >= `USB_FIFO_DEPTH);
                    exp_err = (c16 != `USB_CRC16_RESIDUE);
                    exp_kind = exp_err ? PKT_ERROR : PKT_DATA;
                end
                4'b0010: begin
                    exp_kind = PKT_ACK;
                    exp_err = 1'b0;
                end
                4'b1010: begin
                    exp_kind = PKT_NAK;
                    exp_err = 1'b0;
                end
                default: ;
            endcase
        end
    endtask

    always @(negedge clk) begin : watch
        logic [7:0] exp_byte;
        if (active) begin
            if (flags.packet_done) begin
                done_cnt++;
            end
            if (flags.r_error && !err_prev) begin
                err_cnt++;
            end
            err_prev = flags.r_error;
            if (flags.store_rx_packet) begin
                store_cnt++;
            end
            if (rx_full) begin
                full_seen = 1'b1;
            end
            if (get_rx_data && !rx_empty) begin
                if (exp_q.size() == 0) begin
                    $display("The FIFO returned a byte that no packet should have stored");
                    test_errs++;
                end else begin
                    exp_byte = exp_q.pop_front();
                    check_value("rx_data", exp_byte, rx_data);
                end
            end
        end
    end

    task end_test;
        active = 1'b0;
        check_value("packet_done pulses", exp_err ? 0 : 1, done_cnt);
        check_value("r_error rises", exp_err ? 1 : 0, err_cnt);
        check_value("rx_packet", exp_kind, rx_packet);
        check_value("store_rx_packet pulses", exp_store ? 1 : 0, store_cnt);
        if (exp_full && !full_seen) begin
            $display("rx_full never went high although the packet overflowed the FIFO");
            test_errs++;
        end else if (!exp_full && full_seen) begin
            $display("rx_full went high although the packet fit in the FIFO");
            test_errs++;
        end
        if (exp_q.size() != 0) begin
            $display("The FIFO ran empty with %0d expected bytes still unread", exp_q.size());
            test_errs++;
        end
        if (!rx_empty) begin
            $display("The FIFO still holds bytes after it was drained");
            test_errs++;
        end
        report_test();
    endtask

endmodule

//--- bench/usb_rx_sva.sv
`timescale 1ns/1ns

module usb_rx_sva import usb_rx_pkg::*; (
    input logic         clk,
    input logic         n_rst,
    input line_status_t line,
    input logic         one_byte,
    input rx_flags_t    flags
);
    int sva_fails = 0;

    byte_pulse: assert property (@(posedge clk) disable iff (!n_rst)
        one_byte |=> !one_byte)
        else begin
            $error("one_byte lasted more than one clock");
            sva_fails = sva_fails + 1;
        end

    byte_not_at_eop: assert property (@(posedge clk) disable iff (!n_rst)
        one_byte |-> !line.eop)
        else begin
            $error("one_byte and eop arrived in the same clock");
            sva_fails = sva_fails + 1;
        end

    edge_when_idle: assert property (@(posedge clk) disable iff (!n_rst)
        line.first_edge |-> !flags.receiving)
        else begin
            $error("A new packet started while the last one was still being received");
            sva_fails = sva_fails + 1;
        end

endmodule

bind usb_rcu usb_rx_sva rcu_sva (
    .clk(clk), .n_rst(n_rst), .line(line), .one_byte(one_byte), .flags(flags)
);

//--- hdl/usb_bit_deserializer.sv
`timescale 1ns/1ns
`include "usb_rx_config.svh"

module usb_bit_deserializer import usb_rx_pkg::*; (
    input  logic         clk,
    input  logic         n_rst,
    input  line_status_t line,
    input  logic         timer_clear,
    output logic         shift_enable,
    output logic         one_byte,
    output logic [7:0]   rcv_data
);
    localparam int CW = $clog2(`USB_CLKS_PER_BIT);
    localparam logic [CW-1:0] LAST_CLK = CW'(`USB_CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] MID_CLK = CW'(`USB_CLKS_PER_BIT / 2 - 1);

    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    shift_reg;
    logic          running;
    logic          do_shift;

    assign shift_enable = running && (clk_cnt == MID_CLK); // Middle of the bit in the registered line.
    assign do_shift = shift_enable && !line.eop;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            running  <= 1'b0;
            one_byte <= 1'b0;
        end else begin
            one_byte <= do_shift && (bit_cnt == 3'd7);
            if (line.first_edge) begin
                running <= 1'b1;
            end else if (line.eop) begin
                running <= 1'b0;
            end
            if (line.first_edge || timer_clear) begin
                clk_cnt <= '0;
                bit_cnt <= '0;
            end else begin
                if (running) begin
                    clk_cnt <= (clk_cnt == LAST_CLK) ? '0 : clk_cnt + 1'b1;
                end
                if (do_shift) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_shift) begin
            shift_reg <= {shift_reg[6:0], line.bit_value};
            if (bit_cnt == 3'd7) begin
                rcv_data <= {shift_reg[6:0], line.bit_value}; // Held until the next full byte.
            end
        end
    end

endmodule

//--- hdl/usb_line_decoder.sv
`timescale 1ns/1ns

module usb_line_decoder import usb_rx_pkg::*; (
    input  logic         clk,
    input  logic         n_rst,
    input  logic         dp,
    input  logic         dm,
    input  logic         shift_enable,
    output line_status_t line
);
    logic dp_s, dp_q;
    logic dm_s, dm_q;
    logic dp_prev;
    logic idle_line;
    logic eop_hold;
    logic edge_r;
    logic se0;
    logic line_j;
    logic edge_hit;

    assign se0 = !dp_q && !dm_q;
    assign line_j = dp_q && !dm_q;
    assign edge_hit = idle_line && (dp_s != dp_q); // First change of dp while the bus is idle.

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            dp_s      <= 1'b1; // Line rests in J.
            dp_q      <= 1'b1;
            dm_s      <= 1'b0;
            dm_q      <= 1'b0;
            dp_prev   <= 1'b1;
            idle_line <= 1'b1;
            eop_hold  <= 1'b0;
            edge_r    <= 1'b0;
        end else begin
            dp_s   <= dp;
            dm_s   <= dm;
            dp_q   <= dp_s;
            dm_q   <= dm_s;
            edge_r <= edge_hit;
            if (edge_hit) begin
                idle_line <= 1'b0;
            end else if (eop_hold && line_j) begin
                idle_line <= 1'b1; // Back to J after SE0.
            end
            if (edge_hit) begin
                eop_hold <= 1'b0;
            end else if (shift_enable && se0) begin
                eop_hold <= 1'b1;
            end
            if (idle_line || shift_enable) begin
                dp_prev <= dp_q;
            end
        end
    end

    assign line.first_edge = edge_r;
    assign line.eop = eop_hold || (shift_enable && se0);
    assign line.bit_value = dp_q ~^ dp_prev; // No change reads as a one.

endmodule

//--- hdl/usb_rcu.sv
`timescale 1ns/1ns
`include "usb_rx_config.svh"

module usb_rcu import usb_rx_pkg::*; (
    input  logic         clk,
    input  logic         n_rst,
    input  line_status_t line,
    input  logic         one_byte,
    input  logic [7:0]   rcv_data,
    input  logic         crc5_err,
    input  logic         crc16_err,
    output rx_packet_t   rx_packet,
    output rx_flags_t    flags,
    output logic         w_enable_buffer,
    output logic         timer_clear
);
    localparam logic [3:0] BYTE_SAT = 4'(`USB_CLKS_PER_BIT);

    rcu_state_t state, next_state;
    rx_packet_t next_rx_packet;
    logic       endp_lsb, next_endp_lsb;
    logic       first_write;
    logic       store_q;
    logic [3:0] since_byte;
    logic       byte_aligned;

    // A byte-aligned eop lands less than one bit period after the last byte strobe.
    assign byte_aligned = (since_byte < BYTE_SAT);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state       <= IDLE;
            rx_packet   <= PKT_IDLE;
            endp_lsb    <= 1'b0;
            first_write <= 1'b0;
            store_q     <= 1'b0;
            since_byte  <= BYTE_SAT;
        end else begin
            state     <= next_state;
            rx_packet <= next_rx_packet;
            endp_lsb  <= next_endp_lsb;
            store_q   <= w_enable_buffer && first_write;
            if (state == LOAD_PID && next_state == DATA_STATE) begin
                first_write <= 1'b1;
            end else if (w_enable_buffer) begin
                first_write <= 1'b0;
            end
            if (one_byte) begin
                since_byte <= '0;
            end else if (since_byte < BYTE_SAT) begin
                since_byte <= since_byte + 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        next_rx_packet = rx_packet;
        next_endp_lsb = endp_lsb;
        case (state)
            IDLE, ERROR_STATE, TRANSFER_DONE: begin
                if (line.first_edge) begin
                    next_state = LOAD_SYNC;
                    next_rx_packet = PKT_IDLE;
                end else if (state == TRANSFER_DONE) begin
                    next_state = IDLE; // Done lasts one clock.
                end
            end
            LOAD_SYNC: begin
                if (line.eop || (one_byte && rcv_data != 8'b0000_0001)) begin
                    next_state = ERROR_STATE;
                    next_rx_packet = PKT_ERROR;
                end else if (one_byte) begin
                    next_state = LOAD_PID;
                end
            end
            LOAD_PID: begin
                if (line.eop) begin
                    next_state = ERROR_STATE;
                    next_rx_packet = PKT_ERROR;
                end else if (one_byte) begin
                    case (rcv_data[3:0])
                        4'b0001: begin
                            next_state = TOKEN;
                            next_rx_packet = PKT_OUT;
                        end
                        4'b1001: begin
                            next_state = TOKEN;
                            next_rx_packet = PKT_IN;
                        end
                        4'b0011, 4'b1011: begin
                            next_state = DATA_STATE;
                            next_rx_packet = PKT_DATA;
                        end
                        4'b0010: begin
                            next_state = WAIT_EOP;
                            next_rx_packet = PKT_ACK;
                        end
                        4'b1010: begin
                            next_state = WAIT_EOP;
                            next_rx_packet = PKT_NAK;
                        end
                        default: begin
                            next_state = ERROR_STATE;
                            next_rx_packet = PKT_ERROR;
                        end
                    endcase
                end
            end
            TOKEN: begin
                if (line.eop) begin
                    next_state = ERROR_STATE;
                    next_rx_packet = PKT_ERROR;
                end else if (one_byte) begin
                    if (rcv_data[6:0] == `USB_DEV_ADDR) begin
                        next_state = TOKEN_NUMBER;
                        next_endp_lsb = rcv_data[7]; // Endpoint bit 0 rides in the address byte.
                    end else begin
                        next_state = WAIT_EOP;
                    end
                end
            end
            TOKEN_NUMBER: begin
                if (line.eop) begin
                    next_state = crc5_err ? ERROR_STATE : TRANSFER_DONE;
                    next_rx_packet = crc5_err ? PKT_ERROR : rx_packet;
                end else if (one_byte && {rcv_data[2:0], endp_lsb} != `USB_DEV_ENDP) begin
                    next_state = WAIT_EOP;
                end
            end
            DATA_STATE: begin
                if (line.eop) begin
                    if (byte_aligned && !crc16_err) begin
                        next_state = TRANSFER_DONE;
                    end else begin
                        next_state = ERROR_STATE;
                        next_rx_packet = PKT_ERROR;
                    end
                end
            end
            WAIT_EOP: begin
                if (line.eop) begin
                    next_state = TRANSFER_DONE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        flags.receiving = 1'b0;
        flags.r_error = 1'b0;
        flags.packet_done = 1'b0;
        flags.store_rx_packet = store_q;
        w_enable_buffer = 1'b0;
        timer_clear = 1'b0;
        case (state)
            LOAD_SYNC, LOAD_PID, TOKEN, TOKEN_NUMBER, WAIT_EOP: flags.receiving = 1'b1;
            DATA_STATE: begin
                flags.receiving = 1'b1;
                w_enable_buffer = one_byte; // CRC bytes go in too.
            end
            ERROR_STATE: flags.r_error = 1'b1;
            TRANSFER_DONE: begin
                flags.packet_done = 1'b1;
                timer_clear = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/usb_rx_config.svh
`ifndef USB_RX_CONFIG_SVH
`define USB_RX_CONFIG_SVH

`define USB_CLKS_PER_BIT 4
`define USB_FIFO_DEPTH 8
`define USB_DEV_ADDR 7'h70
`define USB_DEV_ENDP 4'h4
// CRC registers preset to all ones, shift left, sender appends inverted CRC MSB first.
`define USB_CRC5_RESIDUE 5'b01100
`define USB_CRC16_RESIDUE 16'h800D

`endif

//--- hdl/usb_rx_crc.sv
`timescale 1ns/1ns
`include "usb_rx_config.svh"

module usb_rx_crc import usb_rx_pkg::*; (
    input  logic         clk,
    input  logic         n_rst,
    input  line_status_t line,
    input  logic         shift_enable,
    input  logic         one_byte,
    output logic         crc5_err,
    output logic         crc16_err
);
    logic [1:0]  byte_cnt;
    logic        crc_on;
    logic [4:0]  crc5;
    logic [15:0] crc16;
    logic        fb5, fb16;

    assign crc_on = (byte_cnt == 2'd2); // Sync and PID are behind us.
    assign fb5 = line.bit_value ^ crc5[4];
    assign fb16 = line.bit_value ^ crc16[15];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            byte_cnt <= '0;
            crc5     <= '1;
            crc16    <= '1;
        end else if (line.first_edge) begin
            byte_cnt <= '0;
            crc5     <= '1;
            crc16    <= '1;
        end else begin
            if (one_byte && !crc_on) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            if (shift_enable && !line.eop && crc_on) begin
                crc5  <= {crc5[3:0], 1'b0} ^ {2'b00, fb5, 1'b0, fb5};
                crc16 <= {crc16[14:0], 1'b0} ^ {fb16, 12'b0, fb16, 1'b0, fb16};
            end
        end
    end

    // The registers freeze after eop, so the levels hold until the next edge.
    assign crc5_err = (crc5 != `USB_CRC5_RESIDUE);
    assign crc16_err = (crc16 != `USB_CRC16_RESIDUE);

endmodule

//--- hdl/usb_rx_fifo.sv
`timescale 1ns/1ns
`include "usb_rx_config.svh"

module usb_rx_fifo (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       w_enable,
    input  logic [7:0] wdata,
    input  logic       rd,
    output logic [7:0] rx_data,
    output logic       empty,
    output logic       full
);
    localparam int DEPTH = `USB_FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wptr, rptr;
    logic [CW-1:0] count;
    logic          do_write, do_read;

    assign empty = (count == '0);
    assign full = (count == CW'(DEPTH));
    assign do_write = w_enable && !full; // Bytes arriving while full are lost.
    assign do_read = rd && !empty;
    assign rx_data = mem[rptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wptr <= (wptr == LAST_PTR) ? '0 : wptr + 1'b1;
            end
            if (do_read) begin
                rptr <= (rptr == LAST_PTR) ? '0 : rptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hdl/usb_rx_pkg.sv
package usb_rx_pkg;

    typedef enum logic [2:0] {
        PKT_IDLE  = 3'd0,
        PKT_IN    = 3'd1,
        PKT_OUT   = 3'd2,
        PKT_DATA  = 3'd3,
        PKT_ACK   = 3'd4,
        PKT_NAK   = 3'd5,
        PKT_ERROR = 3'd6
    } rx_packet_t;

    typedef enum logic [3:0] {
        IDLE, LOAD_SYNC, LOAD_PID, DATA_STATE, TOKEN,
        TOKEN_NUMBER, ERROR_STATE, WAIT_EOP, TRANSFER_DONE
    } rcu_state_t;

    typedef struct packed {
        logic first_edge; // One-cycle pulse on the first transition out of idle.
        logic eop;        // Both wires low at a bit sample, held until the next edge.
        logic bit_value;  // NRZI decoded bit, valid at the shift strobe.
    } line_status_t;

    typedef struct packed {
        logic receiving;
        logic r_error;
        logic packet_done;
        logic store_rx_packet;
    } rx_flags_t;

endpackage

//--- hdl/usb_rx_top.sv
`timescale 1ns/1ns

module usb_rx_top import usb_rx_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       dp,
    input  logic       dm,
    input  logic       get_rx_data,
    output rx_packet_t rx_packet,
    output logic [7:0] rx_data,
    output logic       rx_empty,
    output logic       rx_full,
    output rx_flags_t  flags
);
    line_status_t line;
    logic         shift_enable;
    logic         one_byte;
    logic [7:0]   rcv_data;
    logic         crc5_err, crc16_err;
    logic         w_enable_buffer;
    logic         timer_clear;

    usb_line_decoder u_line_decoder (
        .clk(clk), .n_rst(n_rst), .dp(dp), .dm(dm),
        .shift_enable(shift_enable), .line(line)
    );

    usb_bit_deserializer u_bit_deserializer (
        .clk(clk), .n_rst(n_rst), .line(line), .timer_clear(timer_clear),
        .shift_enable(shift_enable), .one_byte(one_byte), .rcv_data(rcv_data)
    );

    usb_rx_crc u_rx_crc (
        .clk(clk), .n_rst(n_rst), .line(line), .shift_enable(shift_enable),
        .one_byte(one_byte), .crc5_err(crc5_err), .crc16_err(crc16_err)
    );

    usb_rcu u_rcu (
        .clk(clk), .n_rst(n_rst), .line(line), .one_byte(one_byte), .rcv_data(rcv_data),
        .crc5_err(crc5_err), .crc16_err(crc16_err), .rx_packet(rx_packet), .flags(flags),
        .w_enable_buffer(w_enable_buffer), .timer_clear(timer_clear)
    );

    usb_rx_fifo u_rx_fifo (
        .clk(clk), .n_rst(n_rst), .w_enable(w_enable_buffer), .wdata(rcv_data),
        .rd(get_rx_data), .rx_data(rx_data), .empty(rx_empty), .full(rx_full)
    );

endmodule

//--- list.f
+incdir+hdl
hdl/usb_rx_pkg.sv
hdl/usb_line_decoder.sv
hdl/usb_bit_deserializer.sv
hdl/usb_rx_crc.sv
hdl/usb_rcu.sv
hdl/usb_rx_fifo.sv
hdl/usb_rx_top.sv
bench/usb_rx_sva.sv
bench/usb_rx_checker.sv
bench/tb_usb_rx.sv
